//--- verilog/matmul_pkg.sv
// shared sizes and widths for the systolic matmul core
// every RTL file and the testbench refer to these as matmul_pkg::name
package matmul_pkg;

    // array geometry
    localparam int array_dim = 16;  // rows and columns of array and matrices
    localparam int idx_width = 4;   // bits of a row or column index

    // operand and result widths, all signed
    localparam int data_width = 8;   // weight or activation
    localparam int psum_width = 24;  // partial sum and final result

    // result memory
    localparam int addr_width = 8;          // per-bank slice of the write address bus
    localparam int mem_depth  = array_dim;  // words per bank, one per result row

endpackage

//--- verilog/mac_pe.sv
// single processing element of the weight-stationary array
// holds one weight, passes activations right and partial sums down
`timescale 1ns/1ps

module mac_pe (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     load,
    input  logic signed [matmul_pkg::data_width-1:0] weight_in,
    input  logic signed [matmul_pkg::data_width-1:0] act_in,
    input  logic signed [matmul_pkg::psum_width-1:0] psum_in,
    output logic signed [matmul_pkg::data_width-1:0] act_out,
    output logic signed [matmul_pkg::psum_width-1:0] psum_out
);

    logic signed [matmul_pkg::data_width-1:0] weight;  // stationary operand

    // weight stays put until the host reloads this row
    always_ff @(posedge clk) begin
        if (load) begin
            weight <= weight_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            act_out  <= '0;
            psum_out <= '0;
        end else begin
            act_out  <= act_in;  // one cycle to the right
            // sign-extend both operands before the multiply
            psum_out <= psum_in + matmul_pkg::psum_width'(act_in)
                                * matmul_pkg::psum_width'(weight);
        end
    end

endmodule

//--- verilog/sys_arr.sv
// 16x16 weight-stationary systolic grid with input skew and weight loading
// results leave the bottom of column j one cycle after column j-1
// wr_active pulses so the write band lines up with row 0 on each column
`timescale 1ns/1ps

module sys_arr (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 weight_load,
    input  logic [matmul_pkg::idx_width-1:0]                     weight_row,
    input  logic [matmul_pkg::array_dim*matmul_pkg::data_width-1:0] weight_data,
    input  logic                                                 act_valid,
    input  logic [matmul_pkg::array_dim*matmul_pkg::data_width-1:0] act_data,
    output logic [matmul_pkg::array_dim*matmul_pkg::psum_width-1:0] col_out,
    output logic                                                 wr_active,
    output logic                                                 sys_arr_active
);

    logic [matmul_pkg::array_dim-1:0] row_load;  // one load strobe per array row

    // activations travel right, one extra column past the last PE
    logic signed [matmul_pkg::data_width-1:0]
        act_h [matmul_pkg::array_dim][matmul_pkg::array_dim+1];
    // partial sums travel down, row 0 is the zero seed
    logic signed [matmul_pkg::psum_width-1:0]
        psum_v [matmul_pkg::array_dim+1][matmul_pkg::array_dim];

    logic                             running;  // inside the 16-cycle stream
    logic [matmul_pkg::idx_width-1:0] run_cnt;  // cycles since first act_valid

    always_comb begin
        row_load = '0;
        row_load[weight_row] = weight_load;
    end

    // row k sees its activation k cycles late
    for (genvar k = 0; k < matmul_pkg::array_dim; k++) begin : g_skew
        logic signed [matmul_pkg::data_width-1:0] act_row;

        assign act_row = act_valid ? act_data[k*matmul_pkg::data_width +: matmul_pkg::data_width]
                                   : '0;  // idle rows feed zeros

        if (k == 0) begin : g_direct
            assign act_h[k][0] = act_row;
        end else begin : g_delay
            logic signed [matmul_pkg::data_width-1:0] dly [k];

            always_ff @(posedge clk) begin
                dly[0] <= act_row;
                for (int i = 1; i < k; i++) begin
                    dly[i] <= dly[i-1];
                end
            end

            assign act_h[k][0] = dly[k-1];
        end
    end

    for (genvar j = 0; j < matmul_pkg::array_dim; j++) begin : g_edge
        assign psum_v[0][j] = '0;
        assign col_out[j*matmul_pkg::psum_width +: matmul_pkg::psum_width] =
            psum_v[matmul_pkg::array_dim][j];  // bottom row result
    end

    for (genvar k = 0; k < matmul_pkg::array_dim; k++) begin : g_row
        for (genvar j = 0; j < matmul_pkg::array_dim; j++) begin : g_col
            mac_pe u_pe (
                .clk       (clk),
                .reset     (reset),
                .load      (row_load[k]),
                .weight_in (weight_data[j*matmul_pkg::data_width +: matmul_pkg::data_width]),
                .act_in    (act_h[k][j]),
                .psum_in   (psum_v[k][j]),
                .act_out   (act_h[k][j+1]),
                .psum_out  (psum_v[k+1][j])
            );
        end
    end

    // run tracking, wr_active lands 14 cycles after the first row
    always_ff @(posedge clk) begin
        if (reset) begin
            running        <= 1'b0;
            run_cnt        <= '0;
            sys_arr_active <= 1'b0;
        end else if (!running && act_valid) begin
            running        <= 1'b1;
            run_cnt        <= matmul_pkg::idx_width'(1);
            sys_arr_active <= 1'b1;
        end else if (running) begin
            run_cnt <= run_cnt + 1'b1;
            if (&run_cnt) begin
                running <= 1'b0;  // last row of the stream
            end
            if (wr_active) begin
                sys_arr_active <= 1'b0;
            end
        end
    end

    // write controller needs two cycles before bank 0 enables
    assign wr_active = running &&
        (run_cnt == matmul_pkg::idx_width'(matmul_pkg::array_dim - 2));

    // a run is 16 back-to-back rows, no gaps
    a_full_stream: assert property (@(posedge clk) disable iff (reset)
        $rose(running) |-> act_valid [*matmul_pkg::array_dim - 1])
        else $error("act_valid dropped before the end of a run");

endmodule

//--- verilog/wr_control.sv
// diagonal write-enable band and per-bank write addresses for the result memory
// bank j is enabled 16 cycles starting j cycles after bank 0, done flags the end
`timescale 1ns/1ps

module wr_control (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  active,
    input  logic                                                  sys_arr_active,
    output logic [matmul_pkg::array_dim-1:0]                      wr_en,
    output logic [matmul_pkg::array_dim*matmul_pkg::addr_width-1:0] wr_addr,
    output logic                                                  done
);

    logic [matmul_pkg::array_dim-1:0]                       wr_en_c;
    logic [matmul_pkg::array_dim*matmul_pkg::addr_width-1:0] wr_addr_c;
    logic wr_start;    // band in progress
    logic wr_start_c;
    logic wr_dec;      // falling half, shift zeros in
    logic done_c;
    logic top_only;    // only the last bank still enabled
    logic [matmul_pkg::array_dim-1:0] en_fill;

    assign top_only = (wr_en == {1'b1, {(matmul_pkg::array_dim-1){1'b0}}});

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en    <= '0;
            wr_addr  <= '0;
            wr_start <= 1'b0;
            done     <= 1'b0;
        end else begin
            wr_en    <= wr_en_c;
            wr_addr  <= wr_addr_c;
            wr_start <= wr_start_c;
            done     <= done_c;
        end
    end

    always_comb begin
        wr_en_c    = '0;
        wr_addr_c  = wr_addr;
        wr_start_c = wr_start;
        wr_dec     = 1'b0;
        done_c     = done;

        if (active) begin
            wr_start_c = 1'b1;
            done_c     = 1'b0;
        end

        if (wr_start) begin
            // rising while bit 0 is set and not yet full
            wr_dec  = (&wr_en) || (|wr_en && !wr_en[0]);
            wr_en_c = {wr_en[matmul_pkg::array_dim-2:0], !wr_dec};

            // each bank counts its own enabled cycles
            for (int j = 0; j < matmul_pkg::array_dim; j++) begin
                wr_addr_c[j*matmul_pkg::addr_width +: matmul_pkg::addr_width] =
                    wr_addr[j*matmul_pkg::addr_width +: matmul_pkg::addr_width]
                    + matmul_pkg::addr_width'(wr_en[j]);
            end

            if (top_only) begin
                wr_start_c = 1'b0;  // band ends after this cycle
                wr_addr_c  = '0;
            end
        end

        if (top_only) begin
            done_c = 1'b1;
        end

        if (sys_arr_active && done) begin
            done_c = 1'b0;  // next run has begun
        end
    end

    // fill trailing zeros, then a contiguous band leaves no gap
    assign en_fill = wr_en | (wr_en - 1'b1);

    a_band_contiguous: assert property (@(posedge clk) disable iff (reset)
        (en_fill & (en_fill + 1'b1)) == '0)
        else $error("wr_en is not a contiguous band: %h", wr_en);

endmodule

//--- verilog/result_mem.sv
// banked result store, one bank per array column
// each bank writes at its own address, all banks read the same row
`timescale 1ns/1ps

module result_mem (
    input  logic                                                    clk,
    input  logic [matmul_pkg::array_dim-1:0]                        wr_en,
    input  logic [matmul_pkg::array_dim*matmul_pkg::addr_width-1:0] wr_addr,
    input  logic [matmul_pkg::array_dim*matmul_pkg::psum_width-1:0] col_out,
    input  logic [matmul_pkg::idx_width-1:0]                        rd_addr,
    output logic [matmul_pkg::array_dim*matmul_pkg::psum_width-1:0] rd_data
);

    for (genvar j = 0; j < matmul_pkg::array_dim; j++) begin : g_bank
        logic [matmul_pkg::psum_width-1:0] bank [matmul_pkg::mem_depth];
        logic [matmul_pkg::addr_width-1:0] addr;     // this bank's write address
        logic [matmul_pkg::psum_width-1:0] rd_word;  // registered read

        assign addr = wr_addr[j*matmul_pkg::addr_width +: matmul_pkg::addr_width];

        always_ff @(posedge clk) begin
            if (wr_en[j]) begin
                bank[addr[matmul_pkg::idx_width-1:0]] <=
                    col_out[j*matmul_pkg::psum_width +: matmul_pkg::psum_width];
            end
            rd_word <= bank[rd_addr];  // one cycle read latency
        end

        assign rd_data[j*matmul_pkg::psum_width +: matmul_pkg::psum_width] = rd_word;

        // the write band must stay inside the bank
        a_addr_range: assert property (@(posedge clk)
            wr_en[j] |-> (addr < matmul_pkg::mem_depth))
            else $error("bank %0d write address %0d out of range", j, addr);
    end

endmodule

//--- verilog/result_reader.sv
// streams the stored result matrix out row-major, one element per cycle
// starts on the rising edge of done, busy covers stream in through last result
`timescale 1ns/1ps

module result_reader (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    done,
    input  logic                                                    act_valid,
    input  logic [matmul_pkg::array_dim*matmul_pkg::psum_width-1:0] rd_data,
    output logic [matmul_pkg::idx_width-1:0]                        rd_addr,
    output logic                                                    res_valid,
    output logic signed [matmul_pkg::psum_width-1:0]                res_data,
    output logic                                                    busy
);

    logic                             done_q;   // for edge detect
    logic                             reading;
    logic [matmul_pkg::idx_width-1:0] row_cnt;
    logic [matmul_pkg::idx_width-1:0] col_cnt;
    logic [matmul_pkg::idx_width-1:0] col_q;    // column of the word now on rd_data
    logic                             res_last; // final element of the matrix

    assign rd_addr = row_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            done_q    <= 1'b0;
            reading   <= 1'b0;
            row_cnt   <= '0;
            col_cnt   <= '0;
            res_valid <= 1'b0;
            res_last  <= 1'b0;
            busy      <= 1'b0;
        end else begin
            done_q    <= done;
            res_valid <= reading;  // follows the read by one cycle
            res_last  <= reading && (&row_cnt) && (&col_cnt);

            if (done && !done_q && !reading) begin
                reading <= 1'b1;
                row_cnt <= '0;
                col_cnt <= '0;
            end else if (reading) begin
                col_cnt <= col_cnt + 1'b1;
                if (&col_cnt) begin
                    row_cnt <= row_cnt + 1'b1;
                    if (&row_cnt) begin
                        reading <= 1'b0;  // all 256 reads issued
                    end
                end
            end

            if (act_valid) begin
                busy <= 1'b1;
            end else if (res_valid && res_last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        col_q <= col_cnt;
    end

    // pick this cycle's column out of the bank word
    assign res_data = rd_data[col_q*matmul_pkg::psum_width +: matmul_pkg::psum_width];

    // a new write band must not finish while the old matrix is streaming
    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        reading |-> !$rose(done))
        else $error("done rose again during readout");

endmodule

//--- verilog/matmul_unit.sv
// top of the matmul core: array, write control, result memory and reader
// host loads W, streams 16 rows of A, then collects C row-major on res_data
`timescale 1ns/1ps

module matmul_unit (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    weight_load,
    input  logic [matmul_pkg::idx_width-1:0]                        weight_row,
    input  logic [matmul_pkg::array_dim*matmul_pkg::data_width-1:0] weight_data,
    input  logic                                                    act_valid,
    input  logic [matmul_pkg::array_dim*matmul_pkg::data_width-1:0] act_data,
    output logic                                                    res_valid,
    output logic signed [matmul_pkg::psum_width-1:0]                res_data,
    output logic                                                    busy
);

    logic [matmul_pkg::array_dim*matmul_pkg::psum_width-1:0] col_out;
    logic                                                    wr_active;
    logic                                                    sys_arr_active;
    logic [matmul_pkg::array_dim-1:0]                        wr_en;
    logic [matmul_pkg::array_dim*matmul_pkg::addr_width-1:0] wr_addr;
    logic                                                    done;
    logic [matmul_pkg::idx_width-1:0]                        rd_addr;
    logic [matmul_pkg::array_dim*matmul_pkg::psum_width-1:0] rd_data;

    sys_arr u_sys_arr (
        .clk            (clk),
        .reset          (reset),
        .weight_load    (weight_load),
        .weight_row     (weight_row),
        .weight_data    (weight_data),
        .act_valid      (act_valid),
        .act_data       (act_data),
        .col_out        (col_out),
        .wr_active      (wr_active),
        .sys_arr_active (sys_arr_active)
    );

    wr_control u_wr_control (
        .clk            (clk),
        .reset          (reset),
        .active         (wr_active),
        .sys_arr_active (sys_arr_active),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .done           (done)
    );

    result_mem u_result_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .col_out (col_out),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    result_reader u_result_reader (
        .clk       (clk),
        .reset     (reset),
        .done      (done),
        .act_valid (act_valid),
        .rd_data   (rd_data),
        .rd_addr   (rd_addr),
        .res_valid (res_valid),
        .res_data  (res_data),
        .busy      (busy)
    );

endmodule

//--- test/matmul_unit_tb.sv
// random-stimulus testbench for the systolic matmul core
// loads W, streams A, collects C row-major and checks it against a model of C = A*W
// five tests run in sequence under a cycle watchdog
`timescale 1ns/1ps

module matmul_unit_tb;

    localparam int dim = matmul_pkg::array_dim;
    localparam int dw  = matmul_pkg::data_width;
    localparam int pw  = matmul_pkg::psum_width;

    localparam int          clk_period      = 8;
    localparam int          reset_cycles    = 10;
    localparam int          test_count      = 5;
    localparam int          cycles_per_test = 600;  // load, stream, pipeline, 256 reads
    localparam int          timeout_cycles  = test_count * cycles_per_test;
    localparam logic [31:0] seed            = 32'hcce83a5f;

    logic                             clk;
    logic                             reset;
    logic                             weight_load;
    logic [matmul_pkg::idx_width-1:0] weight_row;
    logic [dim*dw-1:0]                weight_data;
    logic                             act_valid;
    logic [dim*dw-1:0]                act_data;
    logic                             res_valid;
    logic signed [pw-1:0]             res_data;
    logic                             busy;

    int          w_mat [dim][dim];  // w_mat[k][j] sits in array row k, column j
    int          a_mat [dim][dim];  // a_mat[r][k], row r streamed on cycle r
    int          exp_c [dim][dim];
    logic [pw-1:0] got [$];         // res_data in arrival order
    logic [31:0] rng_state       = seed;
    int          cycle_count     = 0;
    int          error_count     = 0;
    int          errors_at_start = 0;
    int          test_num        = 0;
    int          passed_count    = 0;

    matmul_unit DUT (
        .clk         (clk),
        .reset       (reset),
        .weight_load (weight_load),
        .weight_row  (weight_row),
        .weight_data (weight_data),
        .act_valid   (act_valid),
        .act_data    (act_data),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("tests failed");
            $finish;
        end
    end

    // gather results in arrival order and check that busy covers each one
    always @(negedge clk) begin
        if (res_valid === 1'b1) begin
            assert (busy === 1'b1) else begin
                $display("error: busy expected 1 actual %h while res_valid is high", busy);
                error_count++;
            end
            got.push_back(res_data);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int rand_byte();
        rng_state = xorshift32(rng_state);
        return int'($signed(rng_state[dw-1:0]));  // signed 8-bit value
    endfunction

    function automatic void random_weights();
        for (int k = 0; k < dim; k++) begin
            for (int j = 0; j < dim; j++) begin
                w_mat[k][j] = rand_byte();
            end
        end
    endfunction

    function automatic void random_acts();
        for (int r = 0; r < dim; r++) begin
            for (int k = 0; k < dim; k++) begin
                a_mat[r][k] = rand_byte();
            end
        end
    endfunction

    // C[r][j] is the sum over k of A[r][k] * W[k][j]
    function automatic void compute_model();
        for (int r = 0; r < dim; r++) begin
            for (int j = 0; j < dim; j++) begin
                exp_c[r][j] = 0;
                for (int k = 0; k < dim; k++) begin
                    exp_c[r][j] += a_mat[r][k] * w_mat[k][j];
                end
            end
        end
    endfunction

    task automatic apply_reset();
        reset       <= 1'b1;
        weight_load <= 1'b0;
        act_valid   <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic load_weights();
        logic [dim*dw-1:0] row_bits;
        for (int k = 0; k < dim; k++) begin
            for (int j = 0; j < dim; j++) begin
                row_bits[j*dw +: dw] = dw'(w_mat[k][j]);
            end
            @(posedge clk);
            weight_load <= 1'b1;
            weight_row  <= matmul_pkg::idx_width'(k);
            weight_data <= row_bits;
        end
        @(posedge clk);
        weight_load <= 1'b0;
    endtask

    // leaves act_valid high after the last row so the caller decides what follows
    task automatic stream_rows(input int rows);
        logic [dim*dw-1:0] row_bits;
        for (int r = 0; r < rows; r++) begin
            for (int k = 0; k < dim; k++) begin
                row_bits[k*dw +: dw] = dw'(a_mat[r][k]);  // element k feeds array row k
            end
            @(posedge clk);
            act_valid <= 1'b1;
            act_data  <= row_bits;
        end
    endtask

    task automatic check_results();
        logic [pw-1:0] exp_bits;
        assert (got.size() == dim * dim) else begin
            $display("wrong number of results: expected %0d strobes, saw %0d",
                     dim * dim, got.size());
            error_count++;
        end
        for (int i = 0; i < got.size() && i < dim * dim; i++) begin
            exp_bits = pw'(exp_c[i / dim][i % dim]);
            assert (got[i] == exp_bits) else begin
                $display("error: res_data C[%0d][%0d] expected %h actual %h",
                         i / dim, i % dim, exp_bits, got[i]);
                error_count++;
            end
        end
    endtask

    // full stream, then wait for busy to drop after the last result
    task automatic run_and_check();
        got.delete();
        stream_rows(dim);
        @(posedge clk);
        act_valid <= 1'b0;
        do @(negedge clk); while (busy !== 1'b0);
        check_results();
    endtask

    task automatic begin_test();
        errors_at_start = error_count;
        test_num++;
    endtask

    task automatic end_test(input string name);
        int fails;
        fails = error_count - errors_at_start;
        if (fails == 0) begin
            passed_count++;
            $display("test %0d %s: pass", test_num, name);
        end else begin
            $display("test %0d %s: %0d mismatches", test_num, name, fails);
        end
    endtask

    initial begin
        weight_row  <= '0;
        weight_data <= '0;
        act_data    <= '0;
        apply_reset();
        repeat (4) @(posedge clk);

        begin_test();
        for (int k = 0; k < dim; k++) begin
            for (int j = 0; j < dim; j++) begin
                w_mat[k][j] = (k == j) ? 1 : 0;
            end
        end
        random_acts();
        exp_c = a_mat;  // identity W passes A through unchanged
        load_weights();
        run_and_check();
        end_test("identity weights");

        begin_test();
        random_weights();
        random_acts();
        compute_model();
        load_weights();
        run_and_check();
        end_test("random run");

        // second run starts on the edge after busy falls
        begin_test();
        random_weights();
        random_acts();
        compute_model();
        load_weights();
        run_and_check();
        random_acts();
        compute_model();
        run_and_check();
        end_test("back-to-back runs");

        begin_test();
        for (int k = 0; k < dim; k++) begin
            for (int j = 0; j < dim; j++) begin
                w_mat[k][j] = -128;
                a_mat[k][j] = -128;
                exp_c[k][j] = dim * 16384;
            end
        end
        load_weights();
        run_and_check();
        end_test("extreme values");

        begin_test();
        random_weights();
        random_acts();
        load_weights();
        stream_rows(7);
        @(posedge clk);
        apply_reset();  // cut the stream off after row 6
        repeat (40) begin
            @(negedge clk);
            assert (res_valid === 1'b0) else begin
                $display("error: res_valid expected 0 actual %h after reset", res_valid);
                error_count++;
            end
            assert (busy === 1'b0) else begin
                $display("error: busy expected 0 actual %h after reset", busy);
                error_count++;
            end
        end
        random_weights();
        random_acts();
        compute_model();
        load_weights();
        run_and_check();
        repeat (20) @(negedge clk);
        assert (got.size() == dim * dim) else begin
            $display("extra res_valid strobes arrived after the run had finished");
            error_count++;
        end
        end_test("reset mid-run");

        $display("summary: %0d tests run, %0d passed, %0d check errors",
                 test_num, passed_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- matmul_unit.f
verilog/matmul_pkg.sv
verilog/mac_pe.sv
verilog/sys_arr.sv
verilog/wr_control.sv
verilog/result_mem.sv
verilog/result_reader.sv
verilog/matmul_unit.sv
test/matmul_unit_tb.sv

//--- Makefile
# Verilator flow for the matmul core: build and run, lint, clean
# any variable can be overridden on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TB_TOP    ?= matmul_unit_tb
RTL_TOP   ?= matmul_unit
FILELIST  ?= matmul_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail comes from the log, not from the simulator exit status
run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
